//--- src/exePkg.sv
package exePkg;

	//////////////////////////////
	// Widths and data types
	//////////////////////////////

	localparam int dataWidth = 32;
	localparam int halfWidth = dataWidth / 2;
	localparam int shamtWidth = 5;
	localparam int countWidth = 6; // Wide enough to hold the full step count.

	typedef logic [dataWidth-1:0] word_t;
	typedef logic [shamtWidth-1:0] shamt_t;
	typedef logic [countWidth-1:0] count_t;

	//////////////////////////////
	// Constants
	//////////////////////////////

	localparam int mulSteps = 32; // One multiplier bit is consumed per cycle.
	localparam word_t floatOne = 32'h3F80_0000; // Single-precision 1.0.

	//////////////////////////////
	// Operation codes
	//////////////////////////////

	// Integer ALU operations. Code 15 is unused and gives zero.
	typedef enum logic [3:0] {
		aluSll = 4'd0,
		aluSrl = 4'd1,
		aluSra = 4'd2,
		aluAdd = 4'd3,
		aluSub = 4'd4,
		aluOr = 4'd5,
		aluAnd = 4'd6,
		aluXor = 4'd7,
		aluSeq = 4'd8,
		aluSne = 4'd9,
		aluSlt = 4'd10,
		aluSgt = 4'd11,
		aluSle = 4'd12,
		aluSge = 4'd13,
		aluLhi = 4'd14
	} aluOp_e;

	// Float unit operations. Codes 6, 7 and 9 to 15 give zero.
	typedef enum logic [3:0] {
		fpuEq = 4'd0,
		fpuNe = 4'd1,
		fpuLt = 4'd2,
		fpuGt = 4'd3,
		fpuLe = 4'd4,
		fpuGe = 4'd5,
		fpuMul = 4'd8
	} fpuOp_e;

	// Serial multiplier FSM.
	typedef enum logic {
		mulIdle = 1'b0,
		mulRun = 1'b1
	} mulState_e;

endpackage

//--- src/mulIf.sv
`timescale 1ns/1ps

// Start strobe and operands go to the multiplier, busy and product come back.
interface mulIf import exePkg::*; ();

	logic start; // One cycle wide, only while busy is low.
	word_t operandA;
	word_t operandB;
	logic busy;
	word_t product; // Holds the last result until the next start.

	modport requester (
		output start,
		output operandA,
		output operandB,
		input busy,
		input product
	);

	modport worker (
		input start,
		input operandA,
		input operandB,
		output busy,
		output product
	);

endinterface

//--- src/intAlu.sv
`timescale 1ns/1ps

module intAlu import exePkg::*; (
	input word_t operandA,
	input word_t operandB,
	input aluOp_e aluOp,
	output word_t aluResult,
	output logic branchFlag
);

	shamt_t shamt;
	word_t sllOut;
	word_t srlOut;
	word_t sraOut;
	word_t addOut;
	word_t subOut;
	word_t lhiOut;
	logic isEqual;
	logic isLess;

	//////////////////////////////
	// Arithmetic, logic and shifts
	//////////////////////////////

	assign shamt = operandB[shamtWidth-1:0]; // Only the low bits of B count.

	assign sllOut = operandA << shamt;
	assign srlOut = operandA >> shamt;
	assign sraOut = word_t'($signed(operandA) >>> shamt);
	assign addOut = operandA + operandB;
	assign subOut = operandA - operandB;
	assign lhiOut = {operandB[halfWidth-1:0], {halfWidth{1'b0}}};

	//////////////////////////////
	// Set-on-compare
	//////////////////////////////

	// Both relations are unsigned; the other four derive from these two.
	assign isEqual = (operandA == operandB);
	assign isLess = (operandA < operandB);

	always_comb begin
		case (aluOp)
			aluSll: aluResult = sllOut;
			aluSrl: aluResult = srlOut;
			aluSra: aluResult = sraOut;
			aluAdd: aluResult = addOut;
			aluSub: aluResult = subOut;
			aluOr: aluResult = operandA | operandB;
			aluAnd: aluResult = operandA & operandB;
			aluXor: aluResult = operandA ^ operandB;
			aluSeq: aluResult = word_t'(isEqual);
			aluSne: aluResult = word_t'(!isEqual);
			aluSlt: aluResult = word_t'(isLess);
			aluSgt: aluResult = word_t'(!isLess && !isEqual);
			aluSle: aluResult = word_t'(isLess || isEqual);
			aluSge: aluResult = word_t'(!isLess);
			aluLhi: aluResult = lhiOut;
			default: aluResult = '0; // Code 15.
		endcase
	end

	assign branchFlag = aluResult[0]; // Set operations put their flag here.

endmodule

//--- src/serialMultiplier.sv
`timescale 1ns/1ps

module serialMultiplier import exePkg::*; (
	input logic clock,
	input logic reset,
	mulIf.worker mul
);

	mulState_e state;
	count_t stepCount;
	word_t multiplicand;
	word_t multiplier;
	word_t accumulator;
	word_t partial;
	logic loadOperands;
	logic lastStep;

	assign loadOperands = (state == mulIdle) && mul.start;
	assign lastStep = (stepCount == count_t'(1));

	// Add the shifted multiplicand when the current multiplier bit is set.
	assign partial = multiplier[0] ? multiplicand : '0;

	//////////////////////////////
	// Control FSM
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= mulIdle;
			stepCount <= '0;
		end else begin
			case (state)
				mulIdle: begin
					if (mul.start) begin
						state <= mulRun;
						stepCount <= count_t'(mulSteps); // Counts down to one.
					end
				end
				mulRun: begin
					stepCount <= stepCount - count_t'(1);
					if (lastStep) begin
						state <= mulIdle;
					end
				end
				default: begin
					state <= mulIdle;
				end
			endcase
		end
	end

	//////////////////////////////
	// Datapath
	//////////////////////////////

	// Product must read zero after reset, so the accumulator is cleared there.
	always_ff @(posedge clock) begin
		if (reset) begin
			accumulator <= '0;
		end else if (loadOperands) begin
			accumulator <= '0;
		end else if (state == mulRun) begin
			accumulator <= accumulator + partial; // Carries above bit 31 drop.
		end
	end

	always_ff @(posedge clock) begin
		if (loadOperands) begin
			multiplicand <= mul.operandA;
			multiplier <= mul.operandB;
		end else if (state == mulRun) begin
			multiplicand <= multiplicand << 1; // Weight of the next bit.
			multiplier <= multiplier >> 1;
		end
	end

	assign mul.busy = (state == mulRun);
	assign mul.product = accumulator;

endmodule

//--- src/fpUnit.sv
`timescale 1ns/1ps

module fpUnit import exePkg::*; (
	input logic clock,
	input logic reset,
	input word_t floatA,
	input word_t floatB,
	input fpuOp_e fpuOp,
	input logic fpuIssue,
	output word_t fpuResult,
	output logic mulStall
);

	mulIf mulBus ();

	logic isEqual;
	logic isLess;
	word_t compareResult;

	//////////////////////////////
	// Multiplier request
	//////////////////////////////

	// An issue that arrives while the multiplier runs is dropped.
	assign mulBus.start = fpuIssue && (fpuOp == fpuMul) && !mulBus.busy;
	assign mulBus.operandA = floatA;
	assign mulBus.operandB = floatB;

	serialMultiplier multiplierInst (
		.clock(clock),
		.reset(reset),
		.mul(mulBus.worker)
	);

	assign mulStall = mulBus.busy;

	//////////////////////////////
	// Compares and result select
	//////////////////////////////

	// Patterns are compared as unsigned words, not as float values.
	assign isEqual = (floatA == floatB);
	assign isLess = (floatA < floatB);

	always_comb begin
		case (fpuOp)
			fpuEq: compareResult = isEqual ? floatOne : '0;
			fpuNe: compareResult = !isEqual ? floatOne : '0;
			fpuLt: compareResult = isLess ? floatOne : '0;
			fpuGt: compareResult = (!isLess && !isEqual) ? floatOne : '0;
			fpuLe: compareResult = (isLess || isEqual) ? floatOne : '0;
			fpuGe: compareResult = !isLess ? floatOne : '0;
			default: compareResult = '0;
		endcase
	end

	always_comb begin
		if (fpuOp == fpuMul) begin
			fpuResult = mulBus.product; // Valid once busy has fallen.
		end else begin
			fpuResult = compareResult;
		end
	end

endmodule

//--- src/executeUnit.sv
`timescale 1ns/1ps

module executeUnit import exePkg::*; (
	input logic clock,
	input logic reset,
	input word_t busA,
	input word_t busB,
	input aluOp_e aluOp,
	input word_t floatA,
	input word_t floatB,
	input fpuOp_e fpuOp,
	input logic fpuIssue,
	output word_t aluResult,
	output logic gpBranch,
	output word_t fpuResult,
	output logic mulStall
);

	word_t aluOut;
	logic aluBranch;
	word_t fpuOut;
	logic fpuStall;

	//////////////////////////////
	// Integer path
	//////////////////////////////

	intAlu aluInst (
		.operandA(busA),
		.operandB(busB),
		.aluOp(aluOp),
		.aluResult(aluOut),
		.branchFlag(aluBranch)
	);

	assign aluResult = aluOut;
	assign gpBranch = aluBranch; // Combinational, same cycle as the operands.

	//////////////////////////////
	// Float path
	//////////////////////////////

	fpUnit fpuInst (
		.clock(clock),
		.reset(reset),
		.floatA(floatA),
		.floatB(floatB),
		.fpuOp(fpuOp),
		.fpuIssue(fpuIssue),
		.fpuResult(fpuOut),
		.mulStall(fpuStall)
	);

	assign fpuResult = fpuOut;
	assign mulStall = fpuStall; // High for the 32 cycles of a multiply.

endmodule

//--- sim/executeUnit_sva.sv
`timescale 1ns/1ps

module executeUnitSva import exePkg::*; (
	input logic clock,
	input logic reset,
	input logic start,
	input logic busy
);

	count_t runLength; // Consecutive sampled cycles with busy high.

	always_ff @(posedge clock) begin
		if (reset) begin
			runLength <= '0;
		end else if (busy) begin
			runLength <= runLength + count_t'(1);
		end else begin
			runLength <= '0;
		end
	end

	startRaisesBusy: assert property (@(posedge clock) disable iff (reset)
		start && !busy |=> busy)
		else $error("Multiplier busy did not rise after a start.");

	// When busy falls it must have been high for exactly one full multiply.
	busyLength: assert property (@(posedge clock) disable iff (reset)
		$fell(busy) |-> runLength == count_t'(mulSteps))
		else $error("Multiplier busy was not high for exactly mulSteps cycles.");

	noStartWhileBusy: assert property (@(posedge clock) disable iff (reset)
		busy |-> !start)
		else $error("Multiplier start was raised while busy.");

	idleAfterReset: assert property (@(posedge clock)
		reset |=> !busy)
		else $error("Multiplier busy was high after reset.");

endmodule

bind serialMultiplier executeUnitSva multiplierChecks (
	.clock(clock),
	.reset(reset),
	.start(mul.start),
	.busy(mul.busy)
);

//--- sim/executeUnitTb.sv
`timescale 1ns/1ps

module executeUnitTb import exePkg::*; ();

	localparam int clockPeriod = 4;
	localparam int aluVectors = 16 * 20;
	localparam int cmpVectors = 6 * 17 + 9;
	localparam int mulCount = 11;
	localparam int margin = 64;
	localparam int limitCycles = mulCount * (mulSteps + 4) + aluVectors + cmpVectors + margin;

	logic clock = 1'b0;
	logic reset;
	word_t busA;
	word_t busB;
	aluOp_e aluOp;
	word_t floatA;
	word_t floatB;
	fpuOp_e fpuOp;
	logic fpuIssue;
	word_t aluResult;
	logic gpBranch;
	word_t fpuResult;
	logic mulStall;

	word_t expAlu;
	word_t expFpu;
	logic checkAlu;
	logic checkFpu;
	string testName;
	int checkCount;
	int valueErrors;
	int timingErrors;
	word_t edgeValues [3] = '{32'h0000_0000, 32'hFFFF_FFFF, 32'h8000_0000};

	executeUnit UUT (
		.clock(clock),
		.reset(reset),
		.busA(busA),
		.busB(busB),
		.aluOp(aluOp),
		.floatA(floatA),
		.floatB(floatB),
		.fpuOp(fpuOp),
		.fpuIssue(fpuIssue),
		.aluResult(aluResult),
		.gpBranch(gpBranch),
		.fpuResult(fpuResult),
		.mulStall(mulStall)
	);

	always #(clockPeriod / 2) clock = ~clock;

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic word_t expectedValue(input bit isFloat, input logic [3:0] op,
			input word_t a, input word_t b);
		logic [2*dataWidth-1:0] wide;
		shamt_t amount;
		int sh;
		word_t result;
		result = '0;
		amount = b[4:0];
		sh = int'(amount);
		if (!isFloat) begin
			case (op)
				aluSll: result = a << sh;
				aluSrl: result = a >> sh;
				aluSra: begin
					for (int i = 0; i < dataWidth; i++) begin
						result[i] = (i + sh < dataWidth) ? a[i + sh] : a[dataWidth-1];
					end
				end
				aluAdd: result = a + b;
				aluSub: result = a - b;
				aluOr: result = a | b;
				aluAnd: result = a & b;
				aluXor: result = a ^ b;
				aluSeq: result = (a == b) ? 32'd1 : 32'd0;
				aluSne: result = (a != b) ? 32'd1 : 32'd0;
				aluSlt: result = (a < b) ? 32'd1 : 32'd0;
				aluSgt: result = (a > b) ? 32'd1 : 32'd0;
				aluSle: result = (a <= b) ? 32'd1 : 32'd0;
				aluSge: result = (a >= b) ? 32'd1 : 32'd0;
				aluLhi: result = {b[15:0], 16'h0000};
				default: result = '0;
			endcase
		end else begin
			case (op)
				fpuEq: result = (a == b) ? floatOne : '0;
				fpuNe: result = (a != b) ? floatOne : '0;
				fpuLt: result = (a < b) ? floatOne : '0;
				fpuGt: result = (a > b) ? floatOne : '0;
				fpuLe: result = (a <= b) ? floatOne : '0;
				fpuGe: result = (a >= b) ? floatOne : '0;
				fpuMul: begin
					wide = 64'(a) * 64'(b);
					result = wide[dataWidth-1:0]; // Only the low word is kept.
				end
				default: result = '0;
			endcase
		end
		return result;
	endfunction

	task automatic checkWord(input string name, input word_t expected, input word_t actual);
		checkCount++;
		assert (actual === expected) else begin
			valueErrors++;
			$display("FAIL %s: expected %08h, actual %08h", name, expected, actual);
		end
	endtask

	// Outputs are combinational, so they are settled by the falling edge.
	always @(negedge clock) begin
		if (checkAlu) begin
			checkWord({testName, " aluResult"}, expAlu, aluResult);
			checkWord({testName, " gpBranch"}, word_t'(expAlu[0]), word_t'(gpBranch));
		end
		if (checkFpu) begin
			checkWord({testName, " fpuResult"}, expFpu, fpuResult);
		end
	end

	//////////////////////////////
	// Stimulus tasks
	//////////////////////////////

	task automatic aluVector(input string name, input aluOp_e op, input word_t a, input word_t b);
		@(posedge clock);
		#1;
		busA = a;
		busB = b;
		aluOp = op;
		expAlu = expectedValue(1'b0, op, a, b);
		testName = name;
		checkAlu = 1'b1;
	endtask

	task automatic floatCompare(input string name, input fpuOp_e op, input word_t a,
			input word_t b);
		@(posedge clock);
		#1;
		floatA = a;
		floatB = b;
		fpuOp = op;
		expFpu = expectedValue(1'b1, op, a, b);
		testName = name;
		checkFpu = 1'b1;
	endtask

	task automatic runMultiply(input string name, input word_t a, input word_t b,
			input bit interfere);
		int stallCycles;
		stallCycles = 0;
		@(posedge clock);
		#1;
		checkFpu = 1'b0;
		floatA = a;
		floatB = b;
		fpuOp = fpuMul;
		fpuIssue = 1'b1;
		@(posedge clock);
		#1;
		fpuIssue = 1'b0;
		assert (mulStall === 1'b1) else begin
			timingErrors++;
			$display("%s: mulStall did not rise on the edge after the issue.", name);
		end
		while (mulStall === 1'b1) begin
			stallCycles++;
			if (interfere && stallCycles == 4) begin
				floatA = ~a; // A different pair that must be ignored.
				floatB = b ^ 32'h0000_0005;
				fpuIssue = 1'b1;
			end else begin
				fpuIssue = 1'b0;
			end
			@(posedge clock);
			#1;
		end
		checkWord({name, " stall cycles"}, word_t'(mulSteps), word_t'(stallCycles));
		expFpu = expectedValue(1'b1, fpuMul, a, b);
		testName = name;
		checkFpu = 1'b1;
		@(posedge clock);
		#1;
		assert (mulStall === 1'b0) else begin
			timingErrors++;
			$display("%s: mulStall rose again although no multiply was accepted.", name);
		end
		checkFpu = 1'b0;
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		word_t x;
		word_t y;
		word_t lo;
		word_t hi;
		void'($urandom(88));
		reset = 1'b1;
		busA = '0;
		busB = '0;
		aluOp = aluSll;
		floatA = '0;
		floatB = '0;
		fpuOp = fpuEq;
		fpuIssue = 1'b0;
		checkAlu = 1'b0;
		checkFpu = 1'b0;
		testName = "";
		checkCount = 0;
		valueErrors = 0;
		timingErrors = 0;
		repeat (5) @(posedge clock);
		#1;
		reset = 1'b0;

		// Product reads zero before any multiply.
		@(posedge clock);
		#1;
		assert (mulStall === 1'b0) else begin
			timingErrors++;
			$display("mulStall was high after reset.");
		end
		fpuOp = fpuMul;
		expFpu = '0;
		testName = "reset product";
		checkFpu = 1'b1;
		@(posedge clock);
		#1;
		checkFpu = 1'b0;

		for (int op = 0; op < 16; op++) begin
			for (int i = 0; i < 3; i++) begin
				for (int j = 0; j < 3; j++) begin
					aluVector($sformatf("alu op %0d edge", op), aluOp_e'(4'(op)),
						edgeValues[i], edgeValues[j]);
				end
			end
			aluVector($sformatf("alu op %0d shift 0", op), aluOp_e'(4'(op)), $urandom(),
				32'hFFFF_FFE0);
			aluVector($sformatf("alu op %0d shift 31", op), aluOp_e'(4'(op)), $urandom(),
				32'h0000_001F);
			x = $urandom();
			aluVector($sformatf("alu op %0d equal", op), aluOp_e'(4'(op)), x, x);
			repeat (8) begin
				aluVector($sformatf("alu op %0d random", op), aluOp_e'(4'(op)), $urandom(),
					$urandom());
			end
		end
		@(posedge clock);
		#1;
		checkAlu = 1'b0;

		for (int op = 0; op < 6; op++) begin
			repeat (5) begin
				x = $urandom();
				y = $urandom();
				if (x == y) begin
					y = x + 32'd1;
				end
				lo = (x < y) ? x : y;
				hi = (x < y) ? y : x;
				floatCompare($sformatf("fpu op %0d equal", op), fpuOp_e'(4'(op)), x, x);
				floatCompare($sformatf("fpu op %0d smaller", op), fpuOp_e'(4'(op)), lo, hi);
				floatCompare($sformatf("fpu op %0d larger", op), fpuOp_e'(4'(op)), hi, lo);
			end
			floatCompare($sformatf("fpu op %0d sign", op), fpuOp_e'(4'(op)), 32'h8000_0000,
				32'h7FFF_FFFF);
			floatCompare($sformatf("fpu op %0d extremes", op), fpuOp_e'(4'(op)), 32'h0,
				32'hFFFF_FFFF);
		end
		for (int op = 6; op < 16; op++) begin
			if (op != 8) begin
				floatCompare($sformatf("fpu op %0d unused", op), fpuOp_e'(4'(op)), $urandom(),
					$urandom());
			end
		end
		@(posedge clock);
		#1;
		checkFpu = 1'b0;

		repeat (4) begin
			runMultiply("mul random", $urandom(), $urandom(), 1'b0);
		end
		runMultiply("mul zero a", 32'h0, $urandom(), 1'b0);
		runMultiply("mul zero b", $urandom(), 32'h0, 1'b0);
		runMultiply("mul one a", 32'h1, $urandom(), 1'b0);
		runMultiply("mul one b", $urandom(), 32'h1, 1'b0);
		runMultiply("mul ones a", 32'hFFFF_FFFF, $urandom(), 1'b0);
		runMultiply("mul ones both", 32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0);
		runMultiply("mul issue during stall", $urandom(), $urandom(), 1'b1);

		$display("Checks: %0d, value errors: %0d, timing errors: %0d", checkCount,
			valueErrors, timingErrors);
		if (valueErrors == 0 && timingErrors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin
		#(limitCycles * clockPeriod);
		$display("Timeout: the tests did not finish within %0d cycles.", limitCycles);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- build.f
src/exePkg.sv
src/mulIf.sv
src/intAlu.sv
src/serialMultiplier.sv
src/fpUnit.sv
src/executeUnit.sv
sim/executeUnit_sva.sv
sim/executeUnitTb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module executeUnitTb -Mdir obj_dir
	./obj_dir/VexecuteUnitTb > sim.log 2>&1 || true
	cat sim.log
	grep -q "=== PASS ===" sim.log
	! grep -q "=== FAIL ===" sim.log

clean:
	rm -rf obj_dir sim.log
